//--- Makefile
VERILATOR := verilator
TOP       := tb_cpu_top
FILELIST  := cpu_top.f
OBJ_DIR   := obj_dir
FLAGS     := --binary --timing --assert --timescale 1ns/1ps -j 0 --Mdir $(OBJ_DIR)
PASS_MSG  := Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# Fails unless the pass message shows up in the simulation output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- cpu_top.f
rtl/cpu_pkg.sv
rtl/instr_buffer.sv
rtl/issue_unit.sv
rtl/exec_lane.sv
rtl/regfile.sv
rtl/cpu_top.sv
testbench/tb_cpu_top.sv

//--- rtl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int XLEN      = 32;
    localparam int NUM_REGS  = 32;
    localparam int REG_AW    = 5;
    localparam int IMM_W     = 14;
    localparam int NUM_LANES = 2;
    localparam int IB_DEPTH  = 8;  // Also the sender's credits after reset
    localparam int IB_AW     = 3;

    // Unlisted codes commit as NOPs without a register write
    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_AND  = 3'd2,
        OP_OR   = 3'd3,
        OP_ADDI = 3'd4
    } op_e;

    typedef struct packed {
        op_e                     op;
        logic [REG_AW-1:0]       rd;
        logic [REG_AW-1:0]       rs1;
        logic [REG_AW-1:0]       rs2;  // Ignored by ADDI
        logic signed [IMM_W-1:0] imm;
    } instr_t;

    // One instruction buffer entry
    typedef struct packed {
        logic [XLEN-1:0] pc;
        instr_t          instr;
    } fetch_t;

    // Issue slot handed from the issue unit to one lane
    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        op_e               op;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   a;
        logic [XLEN-1:0]   b;
    } issue_t;

    // Register write and commit report of one lane
    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        logic              wen;  // Writing op with rd other than zero
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   wdata;
    } commit_t;

endpackage

`default_nettype wire

//--- rtl/cpu_top.sv
`default_nettype none

module cpu_top (
    input  wire logic              clk,
    input  wire logic              rst_i,
    input  wire logic              fetch_valid_i,
    input  wire cpu_pkg::fetch_t   fetch_i,
    output logic [1:0]             credit_o,
    output cpu_pkg::commit_t       commit_o [cpu_pkg::NUM_LANES]
);

    cpu_pkg::fetch_t             ib_head   [cpu_pkg::NUM_LANES];
    logic [cpu_pkg::IB_AW:0]     ib_count;
    logic [1:0]                  iu_pop;
    cpu_pkg::issue_t             iu_issue  [cpu_pkg::NUM_LANES];
    cpu_pkg::commit_t            lane_fwd  [cpu_pkg::NUM_LANES];
    logic [cpu_pkg::REG_AW-1:0]  rf_raddr  [2*cpu_pkg::NUM_LANES];
    logic [cpu_pkg::XLEN-1:0]    rf_rdata  [2*cpu_pkg::NUM_LANES];

    instr_buffer u_instr_buffer (
        .clk         (clk),
        .rst_i       (rst_i),
        .push_i      (fetch_valid_i),
        .push_data_i (fetch_i),
        .pop_i       (iu_pop),
        .head_o      (ib_head),
        .count_o     (ib_count),
        .credit_o    (credit_o)
    );

    issue_unit u_issue_unit (
        .head_i     (ib_head),
        .count_i    (ib_count),
        .pop_o      (iu_pop),
        .rf_raddr_o (rf_raddr),
        .rf_rdata_i (rf_rdata),
        .fwd_i      (lane_fwd),
        .issue_o    (iu_issue)
    );

    // Lane 0 always carries the older instruction
    for (genvar i = 0; i < cpu_pkg::NUM_LANES; i++) begin : g_lane
        exec_lane u_exec_lane (
            .clk     (clk),
            .rst_i   (rst_i),
            .issue_i (iu_issue[i]),
            .fwd_o   (lane_fwd[i]),
            .wb_o    (commit_o[i])  // Commit port doubles as register write
        );
    end

    regfile u_regfile (
        .clk     (clk),
        .rst_i   (rst_i),
        .wr_i    (commit_o),
        .raddr_i (rf_raddr),
        .rdata_o (rf_rdata)
    );

endmodule

`default_nettype wire

//--- rtl/exec_lane.sv
`default_nettype none

module exec_lane (
    input  wire logic             clk,
    input  wire logic             rst_i,
    input  wire cpu_pkg::issue_t  issue_i,
    output cpu_pkg::commit_t      fwd_o,
    output cpu_pkg::commit_t      wb_o
);

    cpu_pkg::issue_t  ex_q;
    cpu_pkg::commit_t ex_res;
    cpu_pkg::commit_t wb_q;
    logic             writes;

    // Execute stage register
    always_ff @(posedge clk) begin
        if (rst_i) begin
            ex_q.valid <= 1'b0;
        end else begin
            ex_q <= issue_i;
        end
    end

    // ALU
    always_comb begin
        writes       = 1'b1;
        ex_res.wdata = '0;
        case (ex_q.op)
            cpu_pkg::OP_ADD:  ex_res.wdata = ex_q.a + ex_q.b;
            cpu_pkg::OP_SUB:  ex_res.wdata = ex_q.a - ex_q.b;
            cpu_pkg::OP_AND:  ex_res.wdata = ex_q.a & ex_q.b;
            cpu_pkg::OP_OR:   ex_res.wdata = ex_q.a | ex_q.b;
            cpu_pkg::OP_ADDI: ex_res.wdata = ex_q.a + ex_q.b;  // b holds the immediate
            default:          writes = 1'b0;                   // NOP, still commits
        endcase
        ex_res.valid = ex_q.valid;
        ex_res.pc    = ex_q.pc;
        ex_res.rd    = ex_q.rd;
        ex_res.wen   = ex_q.valid && writes && (ex_q.rd != '0);
    end

    assign fwd_o = ex_res;

    // Write-back stage register
    always_ff @(posedge clk) begin
        if (rst_i) begin
            wb_q.valid <= 1'b0;
            wb_q.wen   <= 1'b0;
        end else begin
            wb_q <= ex_res;
        end
    end

    assign wb_o = wb_q;

endmodule

`default_nettype wire

//--- rtl/instr_buffer.sv
`default_nettype none

module instr_buffer (
    input  wire logic                   clk,
    input  wire logic                   rst_i,
    input  wire logic                   push_i,
    input  wire cpu_pkg::fetch_t        push_data_i,
    input  wire logic [1:0]             pop_i,
    output cpu_pkg::fetch_t             head_o [cpu_pkg::NUM_LANES],
    output logic [cpu_pkg::IB_AW:0]     count_o,
    output logic [1:0]                  credit_o
);

    cpu_pkg::fetch_t mem [cpu_pkg::IB_DEPTH];

    logic [cpu_pkg::IB_AW-1:0] wr_ptr_q;
    logic [cpu_pkg::IB_AW-1:0] rd_ptr_q;
    logic [cpu_pkg::IB_AW-1:0] rd_ptr_nxt;  // Second oldest entry
    logic [cpu_pkg::IB_AW:0]   count_q;

    assign rd_ptr_nxt = rd_ptr_q + 1'b1;

    // Entry storage, written at the tail
    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr_q] <= push_data_i;
        end
    end

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            rd_ptr_q <= rd_ptr_q + cpu_pkg::IB_AW'(pop_i);
            count_q  <= count_q + (cpu_pkg::IB_AW + 1)'(push_i)
                                - (cpu_pkg::IB_AW + 1)'(pop_i);
        end
    end

    // Two oldest entries, qualified by count_o downstream
    assign head_o[0] = mem[rd_ptr_q];
    assign head_o[1] = mem[rd_ptr_nxt];
    assign count_o   = count_q;

    // Every freed entry goes straight back to the sender
    assign credit_o  = pop_i;

endmodule

`default_nettype wire

//--- rtl/issue_unit.sv
`default_nettype none

module issue_unit (
    input  wire cpu_pkg::fetch_t            head_i     [cpu_pkg::NUM_LANES],
    input  wire logic [cpu_pkg::IB_AW:0]    count_i,
    output logic [1:0]                      pop_o,
    output logic [cpu_pkg::REG_AW-1:0]      rf_raddr_o [2*cpu_pkg::NUM_LANES],
    input  wire logic [cpu_pkg::XLEN-1:0]   rf_rdata_i [2*cpu_pkg::NUM_LANES],
    input  wire cpu_pkg::commit_t           fwd_i      [cpu_pkg::NUM_LANES],
    output cpu_pkg::issue_t                 issue_o    [cpu_pkg::NUM_LANES]
);

    logic has_one;
    logic has_two;
    logic uses_rs2_1;  // Younger entry reads rs2
    logic dep_on_0;    // Younger entry reads older entry's result
    logic pair;

    // Younger lane in execute wins over older lane, then the register file
    function automatic logic [cpu_pkg::XLEN-1:0] pick_operand(
        input logic [cpu_pkg::REG_AW-1:0] src,
        input logic [cpu_pkg::XLEN-1:0]   rf_val,
        input cpu_pkg::commit_t           ex0,
        input cpu_pkg::commit_t           ex1
    );
        logic [cpu_pkg::XLEN-1:0] val;
        val = rf_val;
        if (src != '0) begin
            if (ex1.wen && ex1.rd == src) begin
                val = ex1.wdata;
            end else if (ex0.wen && ex0.rd == src) begin
                val = ex0.wdata;
            end
        end
        return val;
    endfunction

    function automatic logic [cpu_pkg::XLEN-1:0] sext_imm(
        input logic signed [cpu_pkg::IMM_W-1:0] imm
    );
        return {{(cpu_pkg::XLEN - cpu_pkg::IMM_W){imm[cpu_pkg::IMM_W-1]}}, imm};
    endfunction

    assign has_one = (count_i != '0);
    assign has_two = (count_i >= 2);

    assign uses_rs2_1 = (head_i[1].instr.op != cpu_pkg::OP_ADDI);

    assign dep_on_0 = (head_i[0].instr.rd != '0) &&
                      ((head_i[1].instr.rs1 == head_i[0].instr.rd) ||
                       (uses_rs2_1 && head_i[1].instr.rs2 == head_i[0].instr.rd));

    assign pair = has_two && !dep_on_0;

    always_comb begin
        if (!has_one) begin
            pop_o = 2'd0;
        end else if (pair) begin
            pop_o = 2'd2;
        end else begin
            pop_o = 2'd1;
        end
    end

    // Read both sources of both entries, ADDI simply ignores its rs2 value
    always_comb begin
        for (int i = 0; i < cpu_pkg::NUM_LANES; i++) begin
            rf_raddr_o[2*i]   = head_i[i].instr.rs1;
            rf_raddr_o[2*i+1] = head_i[i].instr.rs2;
        end
    end

    always_comb begin
        for (int i = 0; i < cpu_pkg::NUM_LANES; i++) begin
            issue_o[i].pc = head_i[i].pc;
            issue_o[i].op = head_i[i].instr.op;
            issue_o[i].rd = head_i[i].instr.rd;
            issue_o[i].a  = pick_operand(head_i[i].instr.rs1, rf_rdata_i[2*i],
                                         fwd_i[0], fwd_i[1]);
            if (head_i[i].instr.op == cpu_pkg::OP_ADDI) begin
                issue_o[i].b = sext_imm(head_i[i].instr.imm);
            end else begin
                issue_o[i].b = pick_operand(head_i[i].instr.rs2, rf_rdata_i[2*i+1],
                                            fwd_i[0], fwd_i[1]);
            end
        end
        issue_o[0].valid = has_one;
        issue_o[1].valid = pair;  // Lane 1 only ever takes the younger entry
    end

endmodule

`default_nettype wire

//--- rtl/regfile.sv
`default_nettype none

module regfile (
    input  wire logic                       clk,
    input  wire logic                       rst_i,
    input  wire cpu_pkg::commit_t           wr_i    [cpu_pkg::NUM_LANES],
    input  wire logic [cpu_pkg::REG_AW-1:0] raddr_i [2*cpu_pkg::NUM_LANES],
    output logic [cpu_pkg::XLEN-1:0]        rdata_o [2*cpu_pkg::NUM_LANES]
);

    // Register 0 has no storage
    logic [cpu_pkg::XLEN-1:0] regs [1:cpu_pkg::NUM_REGS-1];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 1; i < cpu_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // Lane 1 last, so the younger write wins
            for (int w = 0; w < cpu_pkg::NUM_LANES; w++) begin
                if (wr_i[w].wen) begin
                    regs[wr_i[w].rd] <= wr_i[w].wdata;
                end
            end
        end
    end

    // Read with write-through, younger lane first
    always_comb begin
        for (int r = 0; r < 2*cpu_pkg::NUM_LANES; r++) begin
            if (raddr_i[r] == '0) begin
                rdata_o[r] = '0;
            end else if (wr_i[1].wen && wr_i[1].rd == raddr_i[r]) begin
                rdata_o[r] = wr_i[1].wdata;
            end else if (wr_i[0].wen && wr_i[0].rd == raddr_i[r]) begin
                rdata_o[r] = wr_i[0].wdata;
            end else begin
                rdata_o[r] = regs[raddr_i[r]];
            end
        end
    end

endmodule

`default_nettype wire

//--- testbench/tb_cpu_top.sv
`default_nettype none

module tb_cpu_top;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          PROG_LEN    = 200;
    localparam int          N_DIRECTED  = 14;    // Leading hand-written instructions
    localparam int          DRIVE_LIMIT = 2000;  // Cycles allowed for pushing the program
    localparam int          DRAIN_LIMIT = 100;   // Cycles allowed for the last commits
    localparam logic [31:0] LFSR_POLY   = 32'h8020_0003;

    logic             clk = 1'b0;
    logic             rst_i;
    logic             fetch_valid_i;
    cpu_pkg::fetch_t  fetch_i;
    logic [1:0]       credit_o;
    cpu_pkg::commit_t commit_o [cpu_pkg::NUM_LANES];

    cpu_pkg::fetch_t  prog [PROG_LEN];
    logic [31:0]      lfsr;
    logic [31:0]      model_regs [cpu_pkg::NUM_REGS];
    int               commit_idx;  // Next program entry expected to commit
    int               credits;
    int               chk_val_errs;
    int               chk_misc_errs;
    int               drv_val_errs;
    int               drv_misc_errs;

    always #20 clk = ~clk;

    cpu_top i_dut (
        .clk           (clk),
        .rst_i         (rst_i),
        .fetch_valid_i (fetch_valid_i),
        .fetch_i       (fetch_i),
        .credit_o      (credit_o),
        .commit_o      (commit_o)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_POLY) : (s >> 1);
    endfunction

    // One LFSR step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic cpu_pkg::instr_t make_instr(input cpu_pkg::op_e op, input int rd,
                                                   input int rs1, input int rs2,
                                                   input int imm);
        cpu_pkg::instr_t ins;
        ins.op  = op;
        ins.rd  = cpu_pkg::REG_AW'(rd);
        ins.rs1 = cpu_pkg::REG_AW'(rs1);
        ins.rs2 = cpu_pkg::REG_AW'(rs2);
        ins.imm = cpu_pkg::IMM_W'(imm);
        return ins;
    endfunction

    function automatic logic op_writes(input cpu_pkg::op_e op);
        return op inside {cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND,
                          cpu_pkg::OP_OR, cpu_pkg::OP_ADDI};
    endfunction

    // Applies one instruction to the model registers and returns its commit
    function automatic cpu_pkg::commit_t model_apply(input cpu_pkg::fetch_t f);
        cpu_pkg::commit_t c;
        logic [31:0]      a;
        logic [31:0]      b;
        logic [31:0]      res;
        int               imm_val;
        a       = model_regs[f.instr.rs1];
        b       = model_regs[f.instr.rs2];
        imm_val = int'(f.instr.imm[12:0]) - (f.instr.imm[13] ? 8192 : 0);  // Two's complement
        case (f.instr.op)
            cpu_pkg::OP_ADD:  res = a + b;
            cpu_pkg::OP_SUB:  res = a - b;
            cpu_pkg::OP_AND:  res = a & b;
            cpu_pkg::OP_OR:   res = a | b;
            cpu_pkg::OP_ADDI: res = a + 32'(imm_val);
            default:          res = '0;
        endcase
        c.valid = 1'b1;
        c.pc    = f.pc;
        c.rd    = f.instr.rd;
        c.wen   = op_writes(f.instr.op) && (f.instr.rd != '0);
        c.wdata = res;
        if (c.wen) begin
            model_regs[f.instr.rd] = res;
        end
        return c;
    endfunction

    task automatic report_value(inout int errs, input string name,
                                input logic [31:0] got, input logic [31:0] exp);
        $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
        errs++;
    endtask

    task automatic build_program();
        logic [31:0] op_bits;
        logic [31:0] rd_bits;
        logic [31:0] rs1_bits;
        logic [31:0] rs2_bits;
        logic [31:0] imm_bits;
        // Dependent chain
        prog[0].instr  = make_instr(cpu_pkg::OP_ADDI, 1, 0, 0, 5);
        prog[1].instr  = make_instr(cpu_pkg::OP_ADDI, 1, 1, 0, -3);
        prog[2].instr  = make_instr(cpu_pkg::OP_ADD, 2, 1, 1, 0);
        prog[3].instr  = make_instr(cpu_pkg::OP_SUB, 3, 2, 1, 0);
        prog[4].instr  = make_instr(cpu_pkg::OP_OR, 4, 3, 2, 0);
        prog[5].instr  = make_instr(cpu_pkg::OP_AND, 5, 4, 3, 0);
        prog[6].instr  = make_instr(cpu_pkg::OP_SUB, 8, 0, 5, 0);      // Negative result
        // Same destination twice, then a reader
        prog[7].instr  = make_instr(cpu_pkg::OP_ADDI, 6, 0, 0, 100);
        prog[8].instr  = make_instr(cpu_pkg::OP_ADDI, 6, 0, 0, 200);
        prog[9].instr  = make_instr(cpu_pkg::OP_ADD, 7, 6, 0, 0);
        prog[10].instr = make_instr(cpu_pkg::OP_ADDI, 0, 1, 0, 7);     // Write to r0
        prog[11].instr = make_instr(cpu_pkg::OP_ADD, 9, 0, 6, 0);
        prog[12].instr = make_instr(cpu_pkg::OP_ADDI, 10, 8, 0, -8192);
        prog[13].instr = make_instr(cpu_pkg::OP_ADDI, 10, 10, 0, 8191);
        // Registers r0 to r7 only to make dependencies frequent
        for (int i = N_DIRECTED; i < PROG_LEN; i++) begin
            op_bits  = take_bits(3);
            rd_bits  = take_bits(3);
            rs1_bits = take_bits(3);
            rs2_bits = take_bits(3);
            imm_bits = take_bits(cpu_pkg::IMM_W);
            prog[i].instr = make_instr(cpu_pkg::op_e'(op_bits[2:0]), int'(rd_bits),
                                       int'(rs1_bits), int'(rs2_bits), int'(imm_bits));
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            prog[i].pc = 32'(i * 4);
        end
    endtask

    task automatic count_credits();
        assert (credit_o <= 2'd2) else
            report_value(drv_val_errs, "credit_o", 32'(credit_o), 32'd2);
        credits = credits + int'(credit_o);
        assert (credits <= cpu_pkg::IB_DEPTH) else begin
            $display("ERROR: %0t more credits came back than were spent", $time);
            drv_misc_errs++;
        end
    endtask

    task automatic check_commit(input int lane, input cpu_pkg::commit_t got);
        cpu_pkg::commit_t exp;
        string            name;
        logic             check_data;
        name = $sformatf("commit_o[%0d]", lane);
        assert (commit_idx < PROG_LEN) else begin
            $display("ERROR: %0t %s committed pc %h after the whole program", $time, name,
                     got.pc);
            chk_misc_errs++;
        end
        if (commit_idx < PROG_LEN) begin
            check_data = op_writes(prog[commit_idx].instr.op);
            exp        = model_apply(prog[commit_idx]);
            assert (got.pc == exp.pc) else
                report_value(chk_val_errs, {name, ".pc"}, got.pc, exp.pc);
            assert (got.wen == exp.wen) else
                report_value(chk_val_errs, {name, ".wen"}, 32'(got.wen), 32'(exp.wen));
            assert (got.rd == exp.rd) else
                report_value(chk_val_errs, {name, ".rd"}, 32'(got.rd), 32'(exp.rd));
            assert (!check_data || got.wdata == exp.wdata) else
                report_value(chk_val_errs, {name, ".wdata"}, got.wdata, exp.wdata);
            commit_idx++;
        end
    endtask

    // Commits are walked lane 0 first, then lane 1
    always @(negedge clk) begin : commit_monitor
        if (rst_i) begin
            commit_idx    = 0;
            chk_val_errs  = 0;
            chk_misc_errs = 0;
            for (int r = 0; r < cpu_pkg::NUM_REGS; r++) begin
                model_regs[r] = '0;
            end
        end else begin
            assert (commit_o[0].valid || !commit_o[1].valid) else begin
                $display("ERROR: %0t lane 1 committed without lane 0", $time);
                chk_misc_errs++;
            end
            for (int lane = 0; lane < cpu_pkg::NUM_LANES; lane++) begin
                if (commit_o[lane].valid) begin
                    check_commit(lane, commit_o[lane]);
                end
            end
        end
    end

    initial begin : driver
        int   idx;
        int   cycles;
        logic idle;
        lfsr          = 32'h7f51;
        credits       = cpu_pkg::IB_DEPTH;
        drv_val_errs  = 0;
        drv_misc_errs = 0;
        rst_i         = 1'b1;
        fetch_valid_i = 1'b0;
        fetch_i       = '0;
        build_program();
        repeat (3) @(posedge clk);
        #1;
        rst_i = 1'b0;

        // Core stays quiet before the first push
        repeat (4) begin
            @(negedge clk);
            assert (credit_o == 2'd0) else
                report_value(drv_val_errs, "credit_o", 32'(credit_o), 32'd0);
            assert (!commit_o[0].valid) else
                report_value(drv_val_errs, "commit_o[0].valid", 32'd1, 32'd0);
            assert (!commit_o[1].valid) else
                report_value(drv_val_errs, "commit_o[1].valid", 32'd1, 32'd0);
        end

        idx    = 0;
        cycles = 0;
        while (idx < PROG_LEN && cycles < DRIVE_LIMIT) begin
            @(posedge clk);
            #1;
            idle = (idx >= N_DIRECTED) && (take_bits(2) == 32'd0);  // Gaps after the burst
            if (credits > 0 && !idle) begin
                fetch_valid_i = 1'b1;
                fetch_i       = prog[idx];
                credits--;
                idx++;
            end else begin
                fetch_valid_i = 1'b0;
            end
            @(negedge clk);
            count_credits();
            cycles++;
        end
        if (idx < PROG_LEN) begin
            $display("ERROR: timeout, only %0d of %0d instructions pushed", idx, PROG_LEN);
            drv_misc_errs++;
        end

        @(posedge clk);
        #1;
        fetch_valid_i = 1'b0;
        cycles        = 0;
        while (commit_idx < PROG_LEN && cycles < DRAIN_LIMIT) begin
            @(negedge clk);
            count_credits();
            @(posedge clk);
            cycles++;
        end
        if (commit_idx < PROG_LEN) begin
            $display("ERROR: timeout, only %0d of %0d instructions committed", commit_idx,
                     PROG_LEN);
            drv_misc_errs++;
        end
        repeat (3) begin  // Room for stray commits
            @(negedge clk);
            count_credits();
        end
        assert (credits == cpu_pkg::IB_DEPTH) else
            report_value(drv_val_errs, "credits", 32'(credits), 32'(cpu_pkg::IB_DEPTH));

        $display("Errors: %0d value mismatches, %0d other failures",
                 chk_val_errs + drv_val_errs, chk_misc_errs + drv_misc_errs);
        if (chk_val_errs + drv_val_errs + chk_misc_errs + drv_misc_errs == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
